//--- snake_pkg.sv
`default_nettype none

package snake_pkg;

    typedef enum logic [2:0] {
        st_idle  = 3'd0,
        st_start = 3'd1,
        st_play  = 3'd2,
        st_over  = 3'd3,
        st_pause = 3'd4
    } game_state_t;

    typedef enum logic [1:0] {
        dir_right = 2'd0,
        dir_down  = 2'd1,
        dir_left  = 2'd2,
        dir_up    = 2'd3
    } dir_t;

    typedef enum logic [2:0] {
        key_hard = 3'd1,
        key_easy = 3'd3,
        key_mid  = 3'd5   // also pause, resume and acknowledge.
    } key_code_t;

    typedef enum logic [2:0] {
        steer_up    = 3'd1,
        steer_down  = 3'd2,
        steer_left  = 3'd3,
        steer_right = 3'd4
    } steer_code_t;

    localparam int max_len   = 10;
    localparam int start_len = 4;
    localparam int len_w     = 4;
    localparam int score_w   = 7;

    localparam int step_w    = 6;   // holds step_easy.
    localparam int step_easy = 60;
    localparam int step_mid  = 40;
    localparam int step_hard = 20;

    localparam int start_x   = 8;   // head cell, tail runs left.
    localparam int start_y   = 15;
    localparam int food_x0   = 15;
    localparam int food_y0   = 10;

endpackage

`default_nettype wire

//--- vga_pkg.sv
`default_nettype none

package vga_pkg;

    localparam int hbp        = 144;   // back porch plus sync.
    localparam int vbp        = 31;

    localparam int cell_px    = 20;
    localparam int grid_w     = 32;
    localparam int grid_h     = 24;
    localparam int cx_w       = 5;
    localparam int cy_w       = 5;

    localparam int rgb_w      = 4;
    localparam logic [rgb_w-1:0] col_on  = '1;
    localparam logic [rgb_w-1:0] col_off = '0;

    // difficulty swatches on the idle screen, in cells.
    localparam int swatch_x0  = 5;
    localparam int swatch_y   = 12;
    localparam int swatch_gap = 10;

endpackage

`default_nettype wire

//--- snake_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module snake_ctrl (
    input  logic                          clk,
    input  logic                          clr,
    input  snake_pkg::key_code_t          key,
    input  logic                          hit,
    input  logic                          eat,
    output snake_pkg::game_state_t        game_state,
    output logic                          step,
    output logic [snake_pkg::score_w-1:0] score
);
    import snake_pkg::*;

    game_state_t       state_nx;
    key_code_t         key_prev;
    logic              key_new;
    logic [1:0]        difficulty;
    logic [step_w-1:0] step_cnt;
    logic [step_w-1:0] step_period;

    assign key_new = (key != key_prev);   // act once per press.

    always_comb
    begin
        case (difficulty)
            2'd1:    step_period = step_w'(step_mid);
            2'd2:    step_period = step_w'(step_hard);
            default: step_period = step_w'(step_easy);
        endcase
    end

    always_comb
    begin
        state_nx = game_state;
        case (game_state)
            st_idle:
                if (key_new && (key == key_hard || key == key_easy || key == key_mid))
                    state_nx = st_start;
            st_start:
                state_nx = st_play;
            st_play:
                if (hit)
                    state_nx = st_over;
                else if (key_new && key == key_mid)
                    state_nx = st_pause;
            st_pause:
                if (key_new && key == key_mid)
                    state_nx = st_play;
            st_over:
                if (key_new && key == key_mid)
                    state_nx = st_idle;
            default:
                state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge clr)
    begin
        if (!clr)
        begin
            game_state <= st_idle;
            key_prev   <= key_code_t'(3'd0);
            difficulty <= 2'd0;
        end
        else
        begin
            game_state <= state_nx;
            key_prev   <= key;
            if (game_state == st_idle && key_new)
            begin
                case (key)
                    key_hard: difficulty <= 2'd2;
                    key_mid:  difficulty <= 2'd1;
                    key_easy: difficulty <= 2'd0;
                    default:  difficulty <= difficulty;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge clr)
    begin
        if (!clr)
        begin
            step_cnt <= '0;
            step     <= 1'b0;
        end
        else
        begin
            step <= 1'b0;
            if (game_state == st_play)
            begin
                if (step_cnt == step_period - 1'b1)
                begin
                    step_cnt <= '0;
                    step     <= (state_nx == st_play);   // no tick into pause.
                end
                else
                    step_cnt <= step_cnt + 1'b1;
            end
            else if (game_state != st_pause)
                step_cnt <= '0;
        end
    end

    always_ff @(posedge clk or negedge clr)
    begin
        if (!clr)
            score <= '0;
        else if (game_state == st_start)
            score <= '0;
        else if (eat && score != '1)
            score <= score + 1'b1;   // saturates at 127.
    end

    a_step_in_play: assert property (@(posedge clk) disable iff (!clr)
        step |-> game_state == st_play);

    a_state_legal: assert property (@(posedge clk) disable iff (!clr)
        game_state inside {st_idle, st_start, st_play, st_pause, st_over});

endmodule

`default_nettype wire

//--- snake_body.sv
`timescale 1ns/1ps
`default_nettype none

module snake_body (
    input  logic                                               clk,
    input  logic                                               clr,
    input  snake_pkg::game_state_t                             game_state,
    input  logic                                               step,
    input  logic                                               eat,
    input  snake_pkg::steer_code_t                             steer,
    output logic [snake_pkg::max_len-1:0][vga_pkg::cx_w-1:0]   seg_x,
    output logic [snake_pkg::max_len-1:0][vga_pkg::cy_w-1:0]   seg_y,
    output logic [snake_pkg::len_w-1:0]                        length,
    output logic                                               hit
);
    import snake_pkg::*;
    import vga_pkg::*;

    dir_t                         dir;
    logic [max_len-1:0][cx_w-1:0] init_x;
    logic [max_len-1:0][cy_w-1:0] init_y;
    logic [cx_w-1:0]              next_x;
    logic [cy_w-1:0]              next_y;
    logic                         wall;
    logic                         self_hit;

    always_comb
    begin
        for (int i = 0; i < max_len; i++)
        begin
            init_x[i] = (i < start_len) ? cx_w'(start_x - i) : '0;
            init_y[i] = (i < start_len) ? cy_w'(start_y) : '0;
        end
    end

    always_ff @(posedge clk or negedge clr)
    begin
        if (!clr)
            dir <= dir_right;
        else if (game_state == st_start)
            dir <= dir_right;
        else if (game_state == st_play)
        begin
            case (steer)   // reverse requests dropped.
                steer_up:    if (dir != dir_down)  dir <= dir_up;
                steer_down:  if (dir != dir_up)    dir <= dir_down;
                steer_left:  if (dir != dir_right) dir <= dir_left;
                steer_right: if (dir != dir_left)  dir <= dir_right;
                default:     dir <= dir;
            endcase
        end
    end

    always_comb
    begin
        next_x = seg_x[0];
        next_y = seg_y[0];
        wall   = 1'b0;
        case (dir)
            dir_right:
            begin
                next_x = seg_x[0] + 1'b1;
                wall   = (seg_x[0] == cx_w'(grid_w - 1));
            end
            dir_left:
            begin
                next_x = seg_x[0] - 1'b1;
                wall   = (seg_x[0] == '0);
            end
            dir_down:
            begin
                next_y = seg_y[0] + 1'b1;
                wall   = (seg_y[0] == cy_w'(grid_h - 1));
            end
            dir_up:
            begin
                next_y = seg_y[0] - 1'b1;
                wall   = (seg_y[0] == '0);
            end
        endcase
    end

    // the tail moves away on the same step, so it is not checked.
    always_comb
    begin
        self_hit = 1'b0;
        for (int i = 1; i < max_len; i++)
        begin
            if (i + 1 < int'(length) && seg_x[i] == next_x && seg_y[i] == next_y)
                self_hit = 1'b1;
        end
    end

    assign hit = step && (game_state == st_play) && (wall || self_hit);

    always_ff @(posedge clk or negedge clr)
    begin
        if (!clr)
        begin
            seg_x  <= init_x;
            seg_y  <= init_y;
            length <= len_w'(start_len);
        end
        else if (game_state == st_start)
        begin
            seg_x  <= init_x;
            seg_y  <= init_y;
            length <= len_w'(start_len);
        end
        else if (step && game_state == st_play && !hit)
        begin
            for (int i = max_len - 1; i > 0; i--)
            begin
                seg_x[i] <= seg_x[i-1];
                seg_y[i] <= seg_y[i-1];
            end
            seg_x[0] <= next_x;
            seg_y[0] <= next_y;
        end
        else if (eat && length < max_len)
        begin
            seg_x[length] <= seg_x[length - 1'b1];   // new tail on old tail.
            seg_y[length] <= seg_y[length - 1'b1];
            length        <= length + 1'b1;
        end
    end

    a_len_range: assert property (@(posedge clk) disable iff (!clr)
        length >= start_len && length <= max_len);

    a_head_in_grid: assert property (@(posedge clk) disable iff (!clr)
        step && game_state == st_play && !hit |=> seg_y[0] < grid_h);

endmodule

`default_nettype wire

//--- food_gen.sv
`timescale 1ns/1ps
`default_nettype none

module food_gen (
    input  logic                       clk,
    input  logic                       clr,
    input  snake_pkg::game_state_t     game_state,
    input  logic [vga_pkg::cx_w-1:0]   head_x,
    input  logic [vga_pkg::cy_w-1:0]   head_y,
    output logic [vga_pkg::cx_w-1:0]   food_x,
    output logic [vga_pkg::cy_w-1:0]   food_y,
    output logic                       eat
);
    import snake_pkg::*;
    import vga_pkg::*;

    logic [cx_w-1:0] grid_x;
    logic [cy_w-1:0] grid_y;

    // free-running scan of the grid, used as the random source.
    always_ff @(posedge clk or negedge clr)
    begin
        if (!clr)
        begin
            grid_x <= '0;
            grid_y <= '0;
        end
        else if (grid_x == cx_w'(grid_w - 1))
        begin
            grid_x <= '0;
            if (grid_y == cy_w'(grid_h - 1))
                grid_y <= '0;
            else
                grid_y <= grid_y + 1'b1;
        end
        else
            grid_x <= grid_x + 1'b1;
    end

    assign eat = (game_state == st_play) && (head_x == food_x) && (head_y == food_y);

    always_ff @(posedge clk or negedge clr)
    begin
        if (!clr)
        begin
            food_x <= cx_w'(food_x0);
            food_y <= cy_w'(food_y0);
        end
        else if (eat)
        begin
            food_x <= grid_x;   // respawn.
            food_y <= grid_y;
        end
    end

    a_food_in_grid: assert property (@(posedge clk) disable iff (!clr)
        eat |=> food_y < grid_h);

endmodule

`default_nettype wire

//--- pixel_render.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_render (
    input  logic                                             vidon,
    input  logic [9:0]                                       hc,
    input  logic [9:0]                                       vc,
    input  snake_pkg::game_state_t                           game_state,
    input  logic [snake_pkg::max_len-1:0][vga_pkg::cx_w-1:0] seg_x,
    input  logic [snake_pkg::max_len-1:0][vga_pkg::cy_w-1:0] seg_y,
    input  logic [snake_pkg::len_w-1:0]                      length,
    input  logic [vga_pkg::cx_w-1:0]                         food_x,
    input  logic [vga_pkg::cy_w-1:0]                         food_y,
    output logic [vga_pkg::rgb_w-1:0]                        red,
    output logic [vga_pkg::rgb_w-1:0]                        green,
    output logic [vga_pkg::rgb_w-1:0]                        blue
);
    import snake_pkg::*;
    import vga_pkg::*;

    logic [9:0]      px;
    logic [9:0]      py;
    logic [9:0]      px_cell;
    logic [9:0]      py_cell;
    logic            in_grid;
    logic [cx_w-1:0] cell_x;
    logic [cy_w-1:0] cell_y;
    logic            is_swatch;
    logic            is_body;
    logic            is_food;
    logic [1:0]      swatch_col;
    logic [1:0]      body_col;

    assign px      = hc - 10'(hbp);
    assign py      = vc - 10'(vbp);
    assign px_cell = px / 10'(cell_px);
    assign py_cell = py / 10'(cell_px);
    assign in_grid = (hc >= 10'(hbp)) && (vc >= 10'(vbp))
                     && (px_cell < 10'(grid_w)) && (py_cell < 10'(grid_h));
    assign cell_x  = px_cell[cx_w-1:0];
    assign cell_y  = py_cell[cy_w-1:0];

    always_comb
    begin
        is_swatch  = 1'b0;
        swatch_col = 2'd0;
        for (int k = 0; k < 3; k++)
        begin
            if (cell_x == cx_w'(swatch_x0 + k * swatch_gap) && cell_y == cy_w'(swatch_y))
            begin
                is_swatch  = 1'b1;
                swatch_col = 2'(k);
            end
        end
    end

    // walk downwards so the lowest segment index wins.
    always_comb
    begin
        is_body  = 1'b0;
        body_col = 2'd0;
        for (int i = max_len - 1; i >= 0; i--)
        begin
            if (i < int'(length) && seg_x[i] == cell_x && seg_y[i] == cell_y)
            begin
                is_body  = 1'b1;
                body_col = 2'(i % 3);
            end
        end
    end

    assign is_food = (food_x == cell_x) && (food_y == cell_y);

    always_comb
    begin
        red   = col_off;
        green = col_off;
        blue  = col_off;
        if (vidon && in_grid)
        begin
            if (game_state == st_idle)
            begin
                if (is_swatch)
                begin
                    case (swatch_col)
                        2'd0:    green = col_on;
                        2'd1:    blue  = col_on;
                        default: red   = col_on;
                    endcase
                end
            end
            else if (is_body)
            begin
                case (body_col)
                    2'd0:
                    begin
                        red   = col_on;   // white.
                        green = col_on;
                        blue  = col_on;
                    end
                    2'd1:    blue = col_on;
                    default: red  = col_on;
                endcase
            end
            else if (is_food)
                green = col_on;
        end
    end

endmodule

`default_nettype wire

//--- snake_top.sv
`timescale 1ns/1ps
`default_nettype none

module snake_top (
    input  logic                          clk,
    input  logic                          clr,
    input  logic                          vidon,
    input  logic [9:0]                    hc,
    input  logic [9:0]                    vc,
    input  snake_pkg::key_code_t          key,
    input  snake_pkg::steer_code_t        steer,
    output logic [vga_pkg::rgb_w-1:0]     red,
    output logic [vga_pkg::rgb_w-1:0]     green,
    output logic [vga_pkg::rgb_w-1:0]     blue,
    output logic [snake_pkg::score_w-1:0] score,
    output snake_pkg::game_state_t        game_state
);
    import snake_pkg::*;
    import vga_pkg::*;

    logic                         step;
    logic                         hit;
    logic                         eat;
    logic [max_len-1:0][cx_w-1:0] seg_x;
    logic [max_len-1:0][cy_w-1:0] seg_y;
    logic [len_w-1:0]             length;
    logic [cx_w-1:0]              head_x;
    logic [cy_w-1:0]              head_y;
    logic [cx_w-1:0]              food_x;
    logic [cy_w-1:0]              food_y;

    assign head_x = seg_x[0];
    assign head_y = seg_y[0];

    snake_ctrl u_ctrl (
        .clk        (clk),
        .clr        (clr),
        .key        (key),
        .hit        (hit),
        .eat        (eat),
        .game_state (game_state),
        .step       (step),
        .score      (score)
    );

    snake_body u_body (
        .clk        (clk),
        .clr        (clr),
        .game_state (game_state),
        .step       (step),
        .eat        (eat),
        .steer      (steer),
        .seg_x      (seg_x),
        .seg_y      (seg_y),
        .length     (length),
        .hit        (hit)
    );

    food_gen u_food (
        .clk        (clk),
        .clr        (clr),
        .game_state (game_state),
        .head_x     (head_x),
        .head_y     (head_y),
        .food_x     (food_x),
        .food_y     (food_y),
        .eat        (eat)
    );

    pixel_render u_render (
        .vidon      (vidon),
        .hc         (hc),
        .vc         (vc),
        .game_state (game_state),
        .seg_x      (seg_x),
        .seg_y      (seg_y),
        .length     (length),
        .food_x     (food_x),
        .food_y     (food_y),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

endmodule

`default_nettype wire

//--- snake_tb.sv
`timescale 1ns/1ps
`default_nettype none

module snake_tb;
    import snake_pkg::*;
    import vga_pkg::*;

    localparam int max_cycles = 20000;   // about 200 easy steps plus margin.

    logic                       clk;
    logic                       clr;
    logic                       vidon;
    logic [9:0]                 hc;
    logic [9:0]                 vc;
    key_code_t                  key;
    steer_code_t                steer;
    logic [rgb_w-1:0]           red;
    logic [rgb_w-1:0]           green;
    logic [rgb_w-1:0]           blue;
    logic [score_w-1:0]         score;
    game_state_t                game_state;

    integer                     seed;
    int                         errors;
    int                         cycles;
    key_code_t                  drv_key;
    steer_code_t                drv_steer;

    // reference model of the game.
    game_state_t                m_state;
    key_code_t                  m_key_prev;
    int                         m_diff;
    int                         m_cnt;
    logic                       m_step;
    int                         m_score;
    dir_t                       m_dir;
    int                         mx[max_len];
    int                         my[max_len];
    int                         m_len;
    int                         m_fx;
    int                         m_fy;
    int                         m_gx;
    int                         m_gy;

    snake_top UUT (
        .clk        (clk),
        .clr        (clr),
        .vidon      (vidon),
        .hc         (hc),
        .vc         (vc),
        .key        (key),
        .steer      (steer),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .score      (score),
        .game_state (game_state)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("Timeout after %0d cycles, the game never reached the expected state.",
                     cycles);
            $display("Errors: %0d", errors + 1);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Error: %s = %0h, expected %0h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic init_model();
        m_state    = st_idle;
        m_key_prev = key_code_t'(3'd0);
        m_diff     = 0;
        m_cnt      = 0;
        m_step     = 1'b0;
        m_score    = 0;
        m_dir      = dir_right;
        m_len      = start_len;
        m_fx       = 15;
        m_fy       = 10;
        m_gx       = 0;
        m_gy       = 0;
        for (int i = 0; i < max_len; i++)
        begin
            mx[i] = (i < start_len) ? start_x - i : 0;
            my[i] = (i < start_len) ? start_y : 0;
        end
    endtask

    // one clock edge of the game, from the values seen before the edge.
    task automatic update_model();
        logic        key_new;
        logic        eat;
        logic        wall;
        logic        self_hit;
        logic        hit;
        logic        new_step;
        int          nx;
        int          ny;
        int          period;
        game_state_t nxt;
        key_new = (key != m_key_prev);
        eat     = (m_state == st_play) && (mx[0] == m_fx) && (my[0] == m_fy);
        nx      = mx[0];
        ny      = my[0];
        case (m_dir)
            dir_right: nx = nx + 1;
            dir_left:  nx = nx - 1;
            dir_down:  ny = ny + 1;
            default:   ny = ny - 1;
        endcase
        wall     = (nx < 0) || (nx >= grid_w) || (ny < 0) || (ny >= grid_h);
        self_hit = 1'b0;
        for (int i = 1; i < m_len - 1; i++)   // tail is skipped.
            if (mx[i] == nx && my[i] == ny)
                self_hit = 1'b1;
        hit    = m_step && (m_state == st_play) && (wall || self_hit);
        period = (m_diff == 2) ? step_hard : (m_diff == 1) ? step_mid : step_easy;

        nxt = m_state;
        case (m_state)
            st_idle:
                if (key_new && (key == key_hard || key == key_easy || key == key_mid))
                    nxt = st_start;
            st_start:
                nxt = st_play;
            st_play:
                if (hit)
                    nxt = st_over;
                else if (key_new && key == key_mid)
                    nxt = st_pause;
            st_pause:
                if (key_new && key == key_mid)
                    nxt = st_play;
            default:
                if (key_new && key == key_mid)
                    nxt = st_idle;
        endcase

        if (m_state == st_start)
        begin
            m_len = start_len;
            for (int i = 0; i < max_len; i++)
            begin
                mx[i] = (i < start_len) ? start_x - i : 0;
                my[i] = (i < start_len) ? start_y : 0;
            end
        end
        else if (m_step && m_state == st_play && !hit)
        begin
            for (int i = max_len - 1; i > 0; i--)
            begin
                mx[i] = mx[i-1];
                my[i] = my[i-1];
            end
            mx[0] = nx;
            my[0] = ny;
        end
        else if (eat && m_len < max_len)
        begin
            mx[m_len] = mx[m_len-1];
            my[m_len] = my[m_len-1];
            m_len     = m_len + 1;
        end

        if (m_state == st_start)
            m_dir = dir_right;
        else if (m_state == st_play)
        begin
            if (steer == steer_up && m_dir != dir_down)
                m_dir = dir_up;
            else if (steer == steer_down && m_dir != dir_up)
                m_dir = dir_down;
            else if (steer == steer_left && m_dir != dir_right)
                m_dir = dir_left;
            else if (steer == steer_right && m_dir != dir_left)
                m_dir = dir_right;
        end

        if (m_state == st_start)
            m_score = 0;
        else if (eat && m_score != 127)
            m_score = m_score + 1;

        if (eat)
        begin
            m_fx = m_gx;
            m_fy = m_gy;
        end
        if (m_gx == grid_w - 1)
        begin
            m_gx = 0;
            m_gy = (m_gy == grid_h - 1) ? 0 : m_gy + 1;
        end
        else
            m_gx = m_gx + 1;

        new_step = 1'b0;
        if (m_state == st_play)
        begin
            if (m_cnt == period - 1)
            begin
                m_cnt    = 0;
                new_step = (nxt == st_play);
            end
            else
                m_cnt = m_cnt + 1;
        end
        else if (m_state != st_pause)
            m_cnt = 0;
        m_step = new_step;

        if (m_state == st_idle && key_new)
        begin
            if (key == key_hard)
                m_diff = 2;
            else if (key == key_mid)
                m_diff = 1;
            else if (key == key_easy)
                m_diff = 0;
        end
        m_state    = nxt;
        m_key_prev = key;
    endtask

    // expected {red, green, blue} of one pixel.
    function automatic logic [11:0] pixel_colour(input logic [9:0] h, input logic [9:0] v,
                                                 input logic on);
        int cx;
        int cy;
        int idx;
        if (!on || h < hbp || v < vbp)
            return 12'h000;
        cx = (h - hbp) / cell_px;
        cy = (v - vbp) / cell_px;
        if (cx >= grid_w || cy >= grid_h)
            return 12'h000;
        if (m_state == st_idle)
        begin
            if (cy == swatch_y && cx == swatch_x0)
                return 12'h0f0;
            if (cy == swatch_y && cx == swatch_x0 + swatch_gap)
                return 12'h00f;
            if (cy == swatch_y && cx == swatch_x0 + 2 * swatch_gap)
                return 12'hf00;
            return 12'h000;
        end
        idx = -1;
        for (int i = m_len - 1; i >= 0; i--)
            if (mx[i] == cx && my[i] == cy)
                idx = i;
        if (idx >= 0)
            return (idx % 3 == 0) ? 12'hfff : (idx % 3 == 1) ? 12'h00f : 12'hf00;
        if (m_fx == cx && m_fy == cy)
            return 12'h0f0;
        return 12'h000;
    endfunction

    task automatic compare_pixel();
        logic [11:0] exp;
        #1;
        exp = pixel_colour(hc, vc, vidon);
        check("red", red, exp[11:8]);
        check("green", green, exp[7:4]);
        check("blue", blue, exp[3:0]);
    endtask

    task automatic probe_cell(input int cx, input int cy);
        vidon = 1'b1;
        hc    = 10'(hbp + cx * cell_px + cell_px / 2);
        vc    = 10'(vbp + cy * cell_px + cell_px / 2);
        compare_pixel();
    endtask

    // a fixed colour expected in one cell.
    task automatic expect_cell(input int cx, input int cy, input logic [11:0] exp);
        vidon = 1'b1;
        hc    = 10'(hbp + cx * cell_px + cell_px / 2);
        vc    = 10'(vbp + cy * cell_px + cell_px / 2);
        #1;
        check("red", red, exp[11:8]);
        check("green", green, exp[7:4]);
        check("blue", blue, exp[3:0]);
    endtask

    // one clock, then new inputs and a random pixel at the falling edge.
    task automatic next_cycle();
        @(posedge clk);
        update_model();
        @(negedge clk);
        key   = drv_key;
        steer = drv_steer;
        vidon = ($random(seed) & 7) != 0;
        hc    = 10'(($random(seed) & 32'h3ff) % 800);
        vc    = 10'(($random(seed) & 32'h3ff) % 525);
        compare_pixel();
        check("game_state", game_state, m_state);
        check("score", score, m_score);
        probe_cell(mx[0], my[0]);
    endtask

    task automatic run_steps(input int n);
        int done;
        done = 0;
        while (done < n)
        begin
            next_cycle();
            if (m_step)
                done = done + 1;
        end
    endtask

    task automatic point_right();
        if (m_dir == dir_left)
        begin
            drv_steer = steer_up;
            next_cycle();
            next_cycle();
        end
        drv_steer = steer_right;
        next_cycle();
        next_cycle();
    endtask

    function automatic steer_code_t toward_food();
        if (m_fx > mx[0] && m_dir != dir_left)
            return steer_right;
        if (m_fx < mx[0] && m_dir != dir_right)
            return steer_left;
        if (m_fy > my[0] && m_dir != dir_up)
            return steer_down;
        if (m_fy < my[0] && m_dir != dir_down)
            return steer_up;
        if (m_fx != mx[0])
            return (my[0] < grid_h / 2) ? steer_down : steer_up;   // turn off the reverse.
        if (m_fy != my[0])
            return (mx[0] < grid_w / 2) ? steer_right : steer_left;
        return steer_code_t'(3'd0);
    endfunction

    task automatic eat_food();
        int start_score;
        start_score = m_score;
        while (m_score == start_score && m_state == st_play)
        begin
            drv_steer = toward_food();
            next_cycle();
        end
        check("score", score, start_score + 1);
        probe_cell(mx[m_len-1], my[m_len-1]);
        probe_cell(m_fx, m_fy);
    endtask

    task automatic press_mid();
        drv_key = key_code_t'(3'd0);
        next_cycle();
        drv_key = key_mid;
        next_cycle();
        next_cycle();
    endtask

    initial
    begin
        int kept_score;
        int frozen_x;
        int frozen_y;
        int rev_x;
        int rev_y;
        seed      = 32'hbdbc_052f;
        errors    = 0;
        cycles    = 0;
        clk       = 1'b0;
        clr       = 1'b0;
        vidon     = 1'b0;
        hc        = '0;
        vc        = '0;
        key       = key_code_t'(3'd0);
        steer     = steer_code_t'(3'd0);
        drv_key   = key_code_t'(3'd0);
        drv_steer = steer_code_t'(3'd0);
        init_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        clr = 1'b1;

        // idle screen.
        check("game_state", game_state, st_idle);
        check("score", score, 0);
        probe_cell(0, 0);
        probe_cell(swatch_x0, swatch_y);
        probe_cell(swatch_x0 + swatch_gap, swatch_y);
        probe_cell(swatch_x0 + 2 * swatch_gap, swatch_y);
        vidon = 1'b0;
        compare_pixel();
        next_cycle();

        // start, then a few steps with random steering.
        drv_key = key_easy;
        next_cycle();
        next_cycle();
        check("game_state", game_state, st_start);
        next_cycle();
        check("game_state", game_state, st_play);
        probe_cell(start_x, start_y);
        probe_cell(15, 10);
        drv_key = key_code_t'(3'd0);
        for (int s = 0; s < 5; s++)
        begin
            drv_steer = steer_code_t'($random(seed) & 7);
            run_steps(1);
        end

        // reverse request while moving right.
        point_right();
        drv_steer = steer_left;
        run_steps(1);
        rev_x = mx[0];
        rev_y = my[0];
        next_cycle();
        expect_cell(rev_x + 1, rev_y, 12'hfff);

        eat_food();
        eat_food();

        // pause holds the body still.
        drv_steer = steer_code_t'(3'd0);
        press_mid();
        check("game_state", game_state, st_pause);
        frozen_x = mx[0];
        frozen_y = my[0];
        repeat (100)
            next_cycle();
        expect_cell(frozen_x, frozen_y, 12'hfff);
        press_mid();
        check("game_state", game_state, st_play);
        drv_key = key_code_t'(3'd0);

        // run into the right wall.
        point_right();
        while (m_state == st_play)
            next_cycle();
        check("game_state", game_state, st_over);
        kept_score = m_score;
        press_mid();
        check("game_state", game_state, st_idle);
        check("score", score, kept_score);
        next_cycle();

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- snake_top.f
snake_pkg.sv
vga_pkg.sv
snake_ctrl.sv
snake_body.sv
food_gen.sv
pixel_render.sv
snake_top.sv
snake_tb.sv
